// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_dummy_insert
FILELIST  := filelist.f
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qx "RESULT: PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== filelist.f ====
+incdir+logic
logic/rv_instr_pkg.sv
logic/xsecure_cfg_pkg.sv
logic/dummy_lfsr_bank.sv
logic/fetch_queue.sv
logic/dummy_issue.sv
logic/dummy_insert_top.sv
sim/tb_dummy_insert.sv

// ==== logic/dummy_insert_top.sv ====
// Dummy instruction inserter
`timescale 1ns/1ps
`include "dummy_macros.svh"

module dummy_insert_top (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        fetch_valid,
  input  rv_instr_pkg::instr_u        fetch_instr,
  output logic                        fetch_full,
  input  logic                        id_ready,
  input  logic                        dummy_en,
  input  xsecure_cfg_pkg::dummy_freq_t dummy_freq,
  input  logic                        seed_we,
  input  xsecure_cfg_pkg::lfsr_idx_t  seed_idx,
  input  logic [`XS_LFSR_W-1:0]       seed_value,
  output logic                        issue_valid,
  output rv_instr_pkg::instr_u        issue_instr,
  output logic                        issue_dummy,
  output logic [`XS_LFSR_W-1:0]       issue_operand_a,
  output logic [`XS_LFSR_W-1:0]       issue_operand_b
);
  import rv_instr_pkg::*;

  instr_u                head_instr;
  logic                  empty;
  logic                  pop;
  logic                  lfsr_step;
  logic [`XS_LFSR_W-1:0] lfsr0;
  logic [`XS_LFSR_W-1:0] lfsr1;
  logic [`XS_LFSR_W-1:0] lfsr2;

  dummy_lfsr_bank i_lfsr_bank (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .lfsr_step  (lfsr_step),
    .seed_we    (seed_we),
    .seed_idx   (seed_idx),
    .seed_value (seed_value),
    .lfsr0      (lfsr0),
    .lfsr1      (lfsr1),
    .lfsr2      (lfsr2)
  );

  fetch_queue i_fetch_queue (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .push       (fetch_valid),
    .push_instr (fetch_instr),
    .pop        (pop),
    .head_instr (head_instr),
    .empty      (empty),
    .full       (fetch_full)
  );

  dummy_issue i_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .id_ready        (id_ready),
    .dummy_en        (dummy_en),
    .dummy_freq      (dummy_freq),
    .head_instr      (head_instr),
    .empty           (empty),
    .lfsr0           (lfsr0),
    .lfsr1           (lfsr1),
    .lfsr2           (lfsr2),
    .pop             (pop),
    .lfsr_step       (lfsr_step),
    .issue_valid     (issue_valid),
    .issue_instr     (issue_instr),
    .issue_dummy     (issue_dummy),
    .issue_operand_a (issue_operand_a),
    .issue_operand_b (issue_operand_b)
  );

endmodule

// ==== logic/dummy_issue.sv ====
// Dummy instruction issue stage
`timescale 1ns/1ps
`include "dummy_macros.svh"

module dummy_issue (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        id_ready,
  input  logic                        dummy_en,
  input  xsecure_cfg_pkg::dummy_freq_t dummy_freq,
  input  rv_instr_pkg::instr_u        head_instr,
  input  logic                        empty,
  input  logic [`XS_LFSR_W-1:0]       lfsr0,
  input  logic [`XS_LFSR_W-1:0]       lfsr1,
  input  logic [`XS_LFSR_W-1:0]       lfsr2,
  output logic                        pop,
  output logic                        lfsr_step,
  output logic                        issue_valid,
  output rv_instr_pkg::instr_u        issue_instr,
  output logic                        issue_dummy,
  output logic [`XS_LFSR_W-1:0]       issue_operand_a,
  output logic [`XS_LFSR_W-1:0]       issue_operand_b
);
  import rv_instr_pkg::*;
  import xsecure_cfg_pkg::*;

  // Wide enough for a target of 64
  localparam int CNT_W = 7;

  logic [CNT_W-1:0] normal_cnt_q;
  logic [CNT_W-1:0] gap_target;
  logic [5:0]       gap_mask;
  logic             dummy_due;
  logic             insert_dummy;
  dummy_kind_t      kind;
  instr_u           dummy_instr;

  // The highest set bit of the setting picks the bound
  always_comb begin
    if (dummy_freq[3]) begin
      gap_mask = `XS_GAP_MASK_64;
    end else if (dummy_freq[2]) begin
      gap_mask = `XS_GAP_MASK_32;
    end else if (dummy_freq[1]) begin
      gap_mask = `XS_GAP_MASK_16;
    end else if (dummy_freq[0]) begin
      gap_mask = `XS_GAP_MASK_8;
    end else begin
      gap_mask = `XS_GAP_MASK_4;
    end
  end

  assign gap_target   = {1'b0, lfsr0[5:0] & gap_mask} + CNT_W'(1);
  assign dummy_due    = (normal_cnt_q == gap_target);
  assign insert_dummy = id_ready && dummy_en && dummy_due;
  assign pop          = id_ready && !insert_dummy && !empty;

  // R-type view for the ALU kinds, B-type view for BLTU with a zero offset
  always_comb begin
    kind        = dummy_kind_t'(lfsr0[7:6]);
    dummy_instr = '0;
    if (kind == DUMMY_BLTU) begin
      dummy_instr.b.opcode = OPCODE_BRANCH;
      dummy_instr.b.funct3 = FUNCT3_BLTU;
      dummy_instr.b.rs1    = lfsr0[12:8];
      dummy_instr.b.rs2    = lfsr0[17:13];
    end else begin
      dummy_instr.r.opcode = OPCODE_OP;
      dummy_instr.r.rd     = REG_X0;
      dummy_instr.r.rs1    = lfsr0[12:8];
      dummy_instr.r.rs2    = lfsr0[17:13];
      // ADD and MUL share funct3 and only MUL sets funct7
      dummy_instr.r.funct3 = (kind == DUMMY_AND) ? FUNCT3_AND : FUNCT3_ADD;
      dummy_instr.r.funct7 = (kind == DUMMY_MUL) ? FUNCT7_MUL : FUNCT7_ADD;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      issue_valid  <= 1'b0;
      issue_dummy  <= 1'b0;
      lfsr_step    <= 1'b0;
      normal_cnt_q <= '0;
    end else begin
      // The bank advances on the cycle after the dummy left
      lfsr_step <= insert_dummy;
      if (id_ready) begin
        if (insert_dummy) begin
          issue_valid  <= 1'b1;
          issue_dummy  <= 1'b1;
          normal_cnt_q <= '0;
        end else if (!empty) begin
          issue_valid  <= 1'b1;
          issue_dummy  <= 1'b0;
          normal_cnt_q <= normal_cnt_q + 1'b1;
        end else begin
          issue_valid <= 1'b0;
          issue_dummy <= 1'b0;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (insert_dummy) begin
      issue_instr     <= dummy_instr;
      issue_operand_a <= lfsr1;
      issue_operand_b <= lfsr2;
    end else if (pop) begin
      issue_instr     <= head_instr;
      issue_operand_a <= '0;
      issue_operand_b <= '0;
    end
  end

  a_dummy_harmless: assert property (@(posedge clk_i) disable iff (!rst_ni)
    issue_valid && issue_dummy |->
      (issue_instr.r.opcode == OPCODE_OP && issue_instr.r.rd == REG_X0) ||
      (issue_instr.b.opcode == OPCODE_BRANCH && issue_instr.b.funct3 == FUNCT3_BLTU &&
       {issue_instr.b.imm_12, issue_instr.b.imm_11, issue_instr.b.imm_10_5,
        issue_instr.b.imm_4_1} == '0))
    else $error("Dummy 0x%08h writes a register or branches away", issue_instr);

endmodule

// ==== logic/dummy_lfsr_bank.sv ====
// Seeded LFSR bank
`timescale 1ns/1ps
`include "dummy_macros.svh"

module dummy_lfsr_bank (
  input  logic                      clk_i,
  input  logic                      rst_ni,
  input  logic                      lfsr_step,
  input  logic                      seed_we,
  input  xsecure_cfg_pkg::lfsr_idx_t seed_idx,
  input  logic [`XS_LFSR_W-1:0]     seed_value,
  output logic [`XS_LFSR_W-1:0]     lfsr0,
  output logic [`XS_LFSR_W-1:0]     lfsr1,
  output logic [`XS_LFSR_W-1:0]     lfsr2
);
  import xsecure_cfg_pkg::*;

  localparam logic [NUM_LFSR-1:0][`XS_LFSR_W-1:0] LFSR_TAPS =
    {`XS_LFSR2_TAPS, `XS_LFSR1_TAPS, `XS_LFSR0_TAPS};
  localparam logic [NUM_LFSR-1:0][`XS_LFSR_W-1:0] LFSR_DEFAULTS =
    {`XS_LFSR2_DEFAULT, `XS_LFSR1_DEFAULT, `XS_LFSR0_DEFAULT};

  logic [NUM_LFSR-1:0][`XS_LFSR_W-1:0] lfsr_q;
  logic [NUM_LFSR-1:0][`XS_LFSR_W-1:0] lfsr_d;

  // One right shift, feedback folded in when the bit shifted out is set
  function automatic logic [`XS_LFSR_W-1:0] galois_step(
    input logic [`XS_LFSR_W-1:0] cur,
    input logic [`XS_LFSR_W-1:0] taps
  );
    logic [`XS_LFSR_W-1:0] nxt;
    nxt = cur >> 1;
    if (cur[0]) begin
      nxt = nxt ^ taps;
    end
    return nxt;
  endfunction

  always_comb begin
    for (int i = 0; i < NUM_LFSR; i++) begin
      lfsr_d[i] = lfsr_q[i];
      // A seed write beats a step on the same LFSR
      if (seed_we && seed_idx == lfsr_idx_t'(i)) begin
        lfsr_d[i] = seed_value;
      end else if (lfsr_step) begin
        lfsr_d[i] = galois_step(lfsr_q[i], LFSR_TAPS[i]);
      end
      // Zero is a fixed point, so recover from it right away
      if (lfsr_d[i] == '0) begin
        lfsr_d[i] = LFSR_DEFAULTS[i];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      lfsr_q <= LFSR_DEFAULTS;
    end else begin
      lfsr_q <= lfsr_d;
    end
  end

  assign lfsr0 = lfsr_q[0];
  assign lfsr1 = lfsr_q[1];
  assign lfsr2 = lfsr_q[2];

  for (genvar g = 0; g < NUM_LFSR; g++) begin : g_lockup_chk
    a_lfsr_nonzero: assert property (@(posedge clk_i) disable iff (!rst_ni)
      lfsr_q[g] != '0)
      else $error("LFSR%0d reached the all zero state", g);
  end

endmodule

// ==== logic/dummy_macros.svh ====
// Dummy inserter build constants
`ifndef DUMMY_MACROS_SVH
`define DUMMY_MACROS_SVH

// LFSR and operand width
`define XS_LFSR_W 32

// Galois feedback masks, one per LFSR
`define XS_LFSR0_TAPS 32'h8000_0057
`define XS_LFSR1_TAPS 32'h8000_0062
`define XS_LFSR2_TAPS 32'h8000_007A

// Reset values, which are also reloaded when an LFSR locks up at zero
`define XS_LFSR0_DEFAULT 32'hAC53_3BF4
`define XS_LFSR1_DEFAULT 32'h5E1D_9C27
`define XS_LFSR2_DEFAULT 32'h3F8B_60D1

// Fetch queue entries, kept a power of two so the pointers wrap by themselves
`define XS_QUEUE_DEPTH 4

// Masks applied to lfsr0[5:0] to bound the gap between dummies
`define XS_GAP_MASK_4  6'd3
`define XS_GAP_MASK_8  6'd7
`define XS_GAP_MASK_16 6'd15
`define XS_GAP_MASK_32 6'd31
`define XS_GAP_MASK_64 6'd63

`endif

// ==== logic/fetch_queue.sv ====
// Fetched instruction FIFO
`timescale 1ns/1ps
`include "dummy_macros.svh"

module fetch_queue (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 push,
  input  rv_instr_pkg::instr_u push_instr,
  input  logic                 pop,
  output rv_instr_pkg::instr_u head_instr,
  output logic                 empty,
  output logic                 full
);
  import rv_instr_pkg::*;

  localparam int DEPTH = `XS_QUEUE_DEPTH;
  localparam int PTR_W = $clog2(DEPTH);

  instr_u           mem_q [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q;
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W:0]   count_q;
  logic             do_push;
  logic             do_pop;

  assign full  = (count_q == (PTR_W+1)'(DEPTH));
  assign empty = (count_q == '0);

  // Words offered while full are simply lost here
  assign do_push = push && !full;
  assign do_pop  = pop && !empty;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + {{PTR_W{1'b0}}, do_push} - {{PTR_W{1'b0}}, do_pop};
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) begin
      mem_q[wr_ptr_q] <= push_instr;
    end
  end

  assign head_instr = mem_q[rd_ptr_q];

  a_no_pop_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pop |-> !empty)
    else $error("Issue stage popped an empty fetch queue");

  a_count_bound: assert property (@(posedge clk_i) disable iff (!rst_ni)
    count_q <= (PTR_W+1)'(DEPTH))
    else $error("Fetch queue count %0d exceeds depth", count_q);

endmodule

// ==== logic/rv_instr_pkg.sv ====
// RISC-V instruction formats
package rv_instr_pkg;

  // Only the two major opcodes a dummy can take are listed
  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_BRANCH = 7'h63
  } opcode_t;

  localparam logic [2:0] FUNCT3_ADD  = 3'b000;
  localparam logic [2:0] FUNCT3_AND  = 3'b111;
  localparam logic [2:0] FUNCT3_MUL  = 3'b000;
  localparam logic [2:0] FUNCT3_BLTU = 3'b110;

  localparam logic [6:0] FUNCT7_ADD = 7'b000_0000;
  localparam logic [6:0] FUNCT7_AND = 7'b000_0000;
  localparam logic [6:0] FUNCT7_MUL = 7'b000_0001;

  localparam logic [4:0] REG_X0 = 5'd0;

  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    opcode_t    opcode;
  } r_type_t;

  // Branch immediate is scattered over the word as in the ISA manual
  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_type_t;

  typedef union packed {
    r_type_t r;
    b_type_t b;
  } instr_u;

endpackage

// ==== logic/xsecure_cfg_pkg.sv ====
// Security feature configuration types
package xsecure_cfg_pkg;

  // Dummy frequency field, decoded by its highest set bit
  typedef logic [3:0] dummy_freq_t;

  // Seed write target, 3 is not mapped to any LFSR
  typedef logic [1:0] lfsr_idx_t;

  localparam int NUM_LFSR = 3;

  typedef enum logic [1:0] {
    DUMMY_ADD  = 2'd0,
    DUMMY_AND  = 2'd1,
    DUMMY_MUL  = 2'd2,
    DUMMY_BLTU = 2'd3
  } dummy_kind_t;

endpackage

// ==== sim/tb_dummy_insert.sv ====
// Dummy inserter testbench
`timescale 1ns/1ps
`include "dummy_macros.svh"

module tb_dummy_insert;
  import rv_instr_pkg::*;
  import xsecure_cfg_pkg::*;

  localparam int CLK_PERIOD   = 100;
  localparam int CYC_RUN      = 300;
  localparam int TOTAL_CYCLES = 210 + 9 * CYC_RUN + 60;
  localparam int WATCHDOG_NS  = (TOTAL_CYCLES * 3 / 2 + 200) * CLK_PERIOD;

  logic                  clk_i;
  logic                  rst_ni;
  logic                  fetch_valid;
  instr_u                fetch_instr;
  logic                  fetch_full;
  logic                  id_ready;
  logic                  dummy_en;
  dummy_freq_t           dummy_freq;
  logic                  seed_we;
  lfsr_idx_t             seed_idx;
  logic [`XS_LFSR_W-1:0] seed_value;
  logic                  issue_valid;
  instr_u                issue_instr;
  logic                  issue_dummy;
  logic [`XS_LFSR_W-1:0] issue_operand_a;
  logic [`XS_LFSR_W-1:0] issue_operand_b;

  // Model state that only the model process writes
  instr_u                mq [$];
  logic [6:0]            cnt;
  logic [`XS_LFSR_W-1:0] lf [3];
  logic                  step_pend;
  logic                  exp_valid;
  logic                  exp_dummy;
  instr_u                exp_instr;
  logic [`XS_LFSR_W-1:0] exp_a;
  logic [`XS_LFSR_W-1:0] exp_b;
  logic                  slot;
  logic                  en_at_edge;
  int                    bound_at_edge;
  logic                  live;
  logic                  full_now;
  logic                  ins;
  logic [`XS_LFSR_W-1:0] nxt;
  int                    full_hits;

  // Owned by the compare process
  int errors;
  int checks;
  int run_len;
  int dummies_seen;
  int kind_count [4];

  // Owned by the stimulus process
  logic [31:0] rng_state;
  int          misc_errors;
  int          tests_done;
  int          err_mark;
  int          mark;
  int          kinds_mark [4];

  dummy_insert_top i_dut (.*);

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic int gap_bound(input dummy_freq_t f);
    return f[3] ? 64 : f[2] ? 32 : f[1] ? 16 : f[0] ? 8 : 4;
  endfunction

  function automatic logic [`XS_LFSR_W-1:0] taps_of(input int i);
    return (i == 0) ? `XS_LFSR0_TAPS : (i == 1) ? `XS_LFSR1_TAPS : `XS_LFSR2_TAPS;
  endfunction

  function automatic logic [`XS_LFSR_W-1:0] default_of(input int i);
    return (i == 0) ? `XS_LFSR0_DEFAULT : (i == 1) ? `XS_LFSR1_DEFAULT : `XS_LFSR2_DEFAULT;
  endfunction

  function automatic logic [`XS_LFSR_W-1:0] galois(input logic [`XS_LFSR_W-1:0] cur,
                                                   input logic [`XS_LFSR_W-1:0] taps);
    return cur[0] ? ((cur >> 1) ^ taps) : (cur >> 1);
  endfunction

  // Expected dummy word for a given lfsr0 value
  function automatic instr_u ref_dummy(input logic [`XS_LFSR_W-1:0] l0);
    logic [31:0] w;
    case (l0[7:6])
      2'd0:    w = {7'b0000000, l0[17:13], l0[12:8], 3'b000, 5'd0, 7'b0110011};
      2'd1:    w = {7'b0000000, l0[17:13], l0[12:8], 3'b111, 5'd0, 7'b0110011};
      2'd2:    w = {7'b0000001, l0[17:13], l0[12:8], 3'b000, 5'd0, 7'b0110011};
      default: w = {7'b0000000, l0[17:13], l0[12:8], 3'b110, 5'd0, 7'b1100011};
    endcase
    return w;
  endfunction

  function automatic int kind_of(input instr_u i);
    logic [31:0] w;
    w = i;
    if (w[6:0] == 7'b1100011) return 3;
    if (w[31:25] == 7'b0000001) return 2;
    return (w[14:12] == 3'b111) ? 1 : 0;
  endfunction

  task automatic check_instr(input string name, input instr_u got, input instr_u exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  task automatic check_word(input string name, input logic [`XS_LFSR_W-1:0] got,
                            input logic [`XS_LFSR_W-1:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t %s: got 0x%h, expected 0x%h", $time, name, got, exp);
    end
  endtask

  // Reference model that steps on the same edge as the DUT
  always @(posedge clk_i) begin
    if (!rst_ni) begin
      mq.delete();
      cnt = '0;
      for (int i = 0; i < 3; i++) lf[i] = default_of(i);
      step_pend = 1'b0;
      exp_valid = 1'b0;
      exp_dummy = 1'b0;
      slot      = 1'b0;
      live      = 1'b1;
    end else begin
      full_now      = (mq.size() == `XS_QUEUE_DEPTH);
      ins           = id_ready && dummy_en &&
                      (cnt == {1'b0, lf[0][5:0] & 6'(gap_bound(dummy_freq) - 1)} + 7'd1);
      slot          = id_ready;
      en_at_edge    = dummy_en;
      bound_at_edge = gap_bound(dummy_freq);
      if (id_ready) begin
        if (ins) begin
          exp_valid = 1'b1;
          exp_dummy = 1'b1;
          exp_instr = ref_dummy(lf[0]);
          exp_a     = lf[1];
          exp_b     = lf[2];
          cnt       = '0;
        end else if (mq.size() != 0) begin
          exp_valid = 1'b1;
          exp_dummy = 1'b0;
          exp_instr = mq.pop_front();
          exp_a     = '0;
          exp_b     = '0;
          cnt       = cnt + 7'd1;
        end else begin
          exp_valid = 1'b0;
          exp_dummy = 1'b0;
        end
      end
      if (fetch_valid && full_now) full_hits++;
      if (fetch_valid && !full_now) mq.push_back(fetch_instr);
      for (int i = 0; i < 3; i++) begin
        nxt = lf[i];
        if (seed_we && seed_idx == lfsr_idx_t'(i)) nxt = seed_value;
        else if (step_pend) nxt = galois(lf[i], taps_of(i));
        lf[i] = (nxt == '0) ? default_of(i) : nxt;
      end
      step_pend = ins;
    end
  end

  // Outputs are settled by the falling edge
  always @(negedge clk_i) begin
    if (live) begin
      check_flag("issue_valid", issue_valid, exp_valid);
      check_flag("issue_dummy", issue_dummy, exp_dummy);
      check_flag("fetch_full", fetch_full, mq.size() == `XS_QUEUE_DEPTH);
      if (exp_valid) begin
        check_instr("issue_instr", issue_instr, exp_instr);
        check_word("issue_operand_a", issue_operand_a, exp_a);
        check_word("issue_operand_b", issue_operand_b, exp_b);
      end
      if (!rst_ni) begin
        run_len = 0;
      end else if (slot && issue_valid) begin
        if (issue_dummy) begin
          run_len = 0;
          dummies_seen++;
          kind_count[kind_of(issue_instr)]++;
        end else begin
          run_len++;
          if (en_at_edge && run_len > bound_at_edge) begin
            errors++;
            $display("%0t: %0d normal instructions in a row, the bound is %0d",
                     $time, run_len, bound_at_edge);
          end
        end
      end
    end
  end

  task automatic apply_reset();
    @(posedge clk_i);
    #1;
    rst_ni      = 1'b0;
    fetch_valid = 1'b0;
    id_ready    = 1'b0;
    seed_we     = 1'b0;
    dummy_en    = 1'b0;
    repeat (2) @(posedge clk_i);
    #1;
    rst_ni = 1'b1;
  endtask

  task automatic drive_cycles(input int n, input int fetch_pct, input int ready_pct);
    for (int k = 0; k < n; k++) begin
      @(posedge clk_i);
      #1;
      seed_we     = 1'b0;
      fetch_valid = (next_rand() % 100) < fetch_pct;
      fetch_instr = next_rand();
      id_ready    = (next_rand() % 100) < ready_pct;
    end
  endtask

  task automatic write_seed(input int idx, input logic [`XS_LFSR_W-1:0] value);
    @(posedge clk_i);
    #1;
    fetch_valid = 1'b0;
    id_ready    = 1'b0;
    seed_we     = 1'b1;
    seed_idx    = lfsr_idx_t'(idx);
    seed_value  = value;
    @(posedge clk_i);
    #1;
    seed_we = 1'b0;
  endtask

  task automatic test_done(input string name);
    tests_done++;
    $display("Test %s: %0d errors", name, errors + misc_errors - err_mark);
    err_mark = errors + misc_errors;
  endtask

  initial begin
    rng_state   = 32'd52;
    rst_ni      = 1'b0;
    fetch_valid = 1'b0;
    fetch_instr = '0;
    id_ready    = 1'b0;
    dummy_en    = 1'b0;
    dummy_freq  = '0;
    seed_we     = 1'b0;
    seed_idx    = '0;
    seed_value  = '0;
    apply_reset();

    // Plain in-order flow with stalls long enough to fill the queue
    mark = full_hits;
    drive_cycles(200, 70, 50);
    drive_cycles(10, 0, 100);
    if (mq.size() != 0 || issue_valid) begin
      misc_errors++;
      $display("The queue did not drain, %0d words still held", mq.size());
    end
    if (full_hits == mark) begin
      misc_errors++;
      $display("The queue never filled, so dropped pushes went unexercised");
    end
    test_done("1 in-order issue without dummies");

    for (int g = 0; g < 5; g++) begin
      apply_reset();
      dummy_en   = 1'b1;
      dummy_freq = dummy_freq_t'((g == 0) ? 0 : (1 << (g - 1)));
      mark       = dummies_seen;
      drive_cycles(CYC_RUN, 90, 100);
      if (dummies_seen == mark) begin
        misc_errors++;
        $display("No dummy was issued with frequency setting %0d", dummy_freq);
      end
    end
    test_done("2 dummy gap bounds");

    apply_reset();
    dummy_en   = 1'b1;
    dummy_freq = '0;
    for (int k = 0; k < 4; k++) kinds_mark[k] = kind_count[k];
    drive_cycles(CYC_RUN, 80, 60);
    for (int k = 0; k < 4; k++) begin
      if (kind_count[k] == kinds_mark[k]) begin
        misc_errors++;
        $display("No dummy of kind %0d was issued", k);
      end
    end
    test_done("3 dummy encoding");

    apply_reset();
    dummy_en   = 1'b1;
    dummy_freq = 4'd1;
    drive_cycles(CYC_RUN, 60, 80);
    test_done("4 dummy operands and LFSR stepping");

    // Seeds are loaded before any issue so the gap count starts clean
    apply_reset();
    write_seed(0, 32'h1357_9BDF);
    write_seed(1, next_rand());
    write_seed(1, '0);
    write_seed(2, next_rand());
    dummy_en   = 1'b1;
    dummy_freq = 4'd2;
    drive_cycles(CYC_RUN / 2, 85, 90);
    write_seed(1, next_rand());
    write_seed(2, '0);
    drive_cycles(CYC_RUN / 2, 85, 90);
    apply_reset();
    write_seed(0, next_rand());
    write_seed(0, '0);
    dummy_en   = 1'b1;
    dummy_freq = 4'd4;
    drive_cycles(CYC_RUN, 85, 90);
    test_done("5 LFSR seeding and zero-seed recovery");

    $display("Tests run: %0d, checks: %0d, errors: %0d",
             tests_done, checks, errors + misc_errors);
    if (errors + misc_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Timeout after %0d ns, the tests did not complete", WATCHDOG_NS);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule
